// File: verilog/mipsPkg.sv
package mipsPkg;

	//////////////////////////////
	// opcodes, instr[31:26]
	localparam logic [5:0] opRtype = 6'h00;
	localparam logic [5:0] opJ     = 6'h02;
	localparam logic [5:0] opBeq   = 6'h04;
	localparam logic [5:0] opBne   = 6'h05;
	localparam logic [5:0] opAddiu = 6'h09;
	localparam logic [5:0] opAndi  = 6'h0c;
	localparam logic [5:0] opOri   = 6'h0d;
	localparam logic [5:0] opLui   = 6'h0f;
	localparam logic [5:0] opLw    = 6'h23;
	localparam logic [5:0] opSw    = 6'h2b;

	// funct codes, instr[5:0] of r-type
	localparam logic [5:0] fnMfhi  = 6'h10;
	localparam logic [5:0] fnMflo  = 6'h12;
	localparam logic [5:0] fnMult  = 6'h18;
	localparam logic [5:0] fnMultu = 6'h19;
	localparam logic [5:0] fnAddu  = 6'h21;
	localparam logic [5:0] fnSubu  = 6'h23;
	localparam logic [5:0] fnAnd   = 6'h24;
	localparam logic [5:0] fnOr    = 6'h25;
	localparam logic [5:0] fnSlt   = 6'h2a;

	// fetch starts here out of reset
	localparam logic [31:0] resetPc = 32'h0000_0000;

	//////////////////////////////
	// control
	typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluLui} aluOpE;

	// writeback source, zero is the alu so a bubble is harmless
	typedef enum logic [1:0] {resAlu, resMem, resHi, resLo} resSelE;

	// all zero is a bubble
	typedef struct packed {
		logic   regWrite;
		logic   regDst;
		logic   aluSrc;
		logic   zeroExt;
		logic   memWrite;
		resSelE resultSel;
		logic   hiloWrite;
		logic   mulSigned;
		aluOpE  aluOp;
	} ctrlT;

	//////////////////////////////
	// stage payloads
	typedef struct packed {
		ctrlT        ctrl;
		logic [31:0] pc;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  dst;
		logic [31:0] srcA;
		logic [31:0] srcB;
		logic [31:0] imm;
	} idExT;

	typedef struct packed {
		ctrlT        ctrl;
		logic [31:0] pc;
		logic [4:0]  dst;
		logic [31:0] aluOut;
		logic [31:0] storeData;
		logic [63:0] product;
	} exMemT;

	typedef struct packed {
		ctrlT        ctrl;
		logic [31:0] pc;
		logic [4:0]  dst;
		logic [31:0] aluOut;
		logic [31:0] readData;
		logic [31:0] hi;
		logic [31:0] lo;
	} memWbT;

endpackage

// File: verilog/hazardIf.sv
`timescale 1ns/1ns

interface hazardIf (
	input logic clk
);
	// register numbers and stage flags, from the datapath
	logic [4:0] rsD, rtD, rsE, rtE;
	logic [4:0] dstE, dstM, dstW;
	logic       regWriteE, regWriteM, regWriteW;
	logic       memToRegE, memToRegM;
	logic       branchD;
	// interlock and bypass controls, from the hazard unit
	logic       stallF, stallD, flushE;
	logic       forwardAD, forwardBD;
	logic [1:0] forwardAE, forwardBE;

	modport hazard (
		input  clk, rsD, rtD, rsE, rtE, dstE, dstM, dstW,
		input  regWriteE, regWriteM, regWriteW, memToRegE, memToRegM, branchD,
		output stallF, stallD, flushE, forwardAD, forwardBD, forwardAE, forwardBE
	);

	modport datapath (
		output rsD, rtD, rsE, rtE, dstE, dstM, dstW,
		output regWriteE, regWriteM, regWriteW, memToRegE, memToRegM, branchD,
		input  stallF, stallD, flushE, forwardAD, forwardBD, forwardAE, forwardBE
	);
endinterface

// File: verilog/pipeReg.sv
`timescale 1ns/1ns

module pipeReg #(
	parameter type T = logic [31:0]
) (
	input  logic clk,
	input  logic rst,
	input  logic stall,
	input  logic flush,
	input  T     d,
	output T     q
);

	// flush beats stall, a cleared payload is a bubble
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			q <= '0;
		end else if (!stall) begin
			q <= d;
		end
	end

endmodule

// File: verilog/controller.sv
`timescale 1ns/1ns

module controller import mipsPkg::*; (
	input  logic [31:0] instr,
	output ctrlT        ctrl,
	output logic        isBranch,
	output logic        branchNe,
	output logic        isJump
);

	logic [5:0] op;
	logic [5:0] funct;

	assign op    = instr[31:26];
	assign funct = instr[5:0];

	always_comb begin
		// anything not listed falls out as a bubble
		ctrl     = '0;
		isBranch = 1'b0;
		branchNe = 1'b0;
		isJump   = 1'b0;
		case (op)
			opRtype: begin
				ctrl.regDst = 1'b1;
				case (funct)
					fnAddu: ctrl.regWrite = 1'b1;
					fnSubu: begin
						ctrl.regWrite = 1'b1;
						ctrl.aluOp    = aluSub;
					end
					fnAnd: begin
						ctrl.regWrite = 1'b1;
						ctrl.aluOp    = aluAnd;
					end
					fnOr: begin
						ctrl.regWrite = 1'b1;
						ctrl.aluOp    = aluOr;
					end
					fnSlt: begin
						ctrl.regWrite = 1'b1;
						ctrl.aluOp    = aluSlt;
					end
					// product lands in hi/lo, no gpr write
					fnMult: begin
						ctrl.hiloWrite = 1'b1;
						ctrl.mulSigned = 1'b1;
					end
					fnMultu: ctrl.hiloWrite = 1'b1;
					fnMfhi: begin
						ctrl.regWrite  = 1'b1;
						ctrl.resultSel = resHi;
					end
					fnMflo: begin
						ctrl.regWrite  = 1'b1;
						ctrl.resultSel = resLo;
					end
					default: ctrl = '0;
				endcase
			end
			opAddiu: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc   = 1'b1;
			end
			// logical immediates are zero extended
			opAndi, opOri, opLui: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc   = 1'b1;
				ctrl.zeroExt  = 1'b1;
				ctrl.aluOp    = (op == opAndi) ? aluAnd : (op == opOri) ? aluOr : aluLui;
			end
			opLw: begin
				ctrl.regWrite  = 1'b1;
				ctrl.aluSrc    = 1'b1;
				ctrl.resultSel = resMem;
			end
			opSw: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc   = 1'b1;
			end
			// branch and jump resolve in decode, ctrl stays a bubble
			opBeq: isBranch = 1'b1;
			opBne: begin
				isBranch = 1'b1;
				branchNe = 1'b1;
			end
			opJ: isJump = 1'b1;
			default: ctrl = '0;
		endcase
	end

	// no encoding both stores and writes a register
	always_comb begin
		assert final (!(ctrl.regWrite && ctrl.memWrite))
			else $error("controller: regWrite and memWrite both set");
	end

endmodule

// File: verilog/regfile.sv
`timescale 1ns/1ns

module regfile #(
	parameter int dataWidth = 32
) (
	input  logic                 clk,
	input  logic [4:0]           ra1,
	input  logic [4:0]           ra2,
	input  logic [4:0]           wa,
	input  logic                 we,
	input  logic [dataWidth-1:0] wd,
	output logic [dataWidth-1:0] rd1,
	output logic [dataWidth-1:0] rd2
);

	logic [dataWidth-1:0] regs [31:0];

	// $0 is never stored
	always_ff @(posedge clk) begin
		if (we && wa != 5'd0) begin
			regs[wa] <= wd;
		end
	end

	// write-through, so writeback reaches decode in the same cycle
	assign rd1 = (ra1 == 5'd0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];
	assign rd2 = (ra2 == 5'd0) ? '0 : (we && wa == ra2) ? wd : regs[ra2];

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ns

module alu import mipsPkg::*; #(
	parameter int dataWidth = 32
) (
	input  logic [dataWidth-1:0] a,
	input  logic [dataWidth-1:0] b,
	input  aluOpE                op,
	output logic [dataWidth-1:0] y
);

	logic lessThan;

	// slt compares as two's complement
	assign lessThan = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			// addu and subu, overflow wraps
			aluAdd: y = a + b;
			aluSub: y = a - b;
			aluAnd: y = a & b;
			aluOr: y = a | b;
			aluSlt: y = {{(dataWidth-1){1'b0}}, lessThan};
			// b arrives as the zero-extended immediate
			aluLui: y = b << 16;
			default: y = '0;
		endcase
	end

endmodule

// File: verilog/hiloUnit.sv
`timescale 1ns/1ns

module hiloUnit #(
	parameter int dataWidth = 32
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [dataWidth-1:0]   a,
	input  logic [dataWidth-1:0]   b,
	input  logic                   mulSigned,
	input  logic                   hiloWrite,
	input  logic [2*dataWidth-1:0] productM,
	output logic [2*dataWidth-1:0] product,
	output logic [dataWidth-1:0]   hi,
	output logic [dataWidth-1:0]   lo
);

	logic signed [2*dataWidth-1:0] prodSigned;
	logic [2*dataWidth-1:0]        prodUnsigned;
	logic [2*dataWidth-1:0]        hiLo;

	// execute, full width product both ways
	assign prodSigned   = $signed(a) * $signed(b);
	assign prodUnsigned = a * b;
	assign product      = mulSigned ? prodSigned : prodUnsigned;

	// written at the edge that ends the memory stage
	always_ff @(posedge clk) begin
		if (rst) begin
			hiLo <= '0;
		end else if (hiloWrite) begin
			hiLo <= productM;
		end
	end

	assign hi = hiLo[2*dataWidth-1:dataWidth];
	assign lo = hiLo[dataWidth-1:0];

endmodule

// File: verilog/hazard.sv
`timescale 1ns/1ns

module hazard (
	hazardIf.hazard hz
);

	logic loadUse;
	logic branchStall;

	//////////////////////////////
	// bypass selects
	// 2'b10 memory, 2'b01 writeback, 2'b00 register file
	assign hz.forwardAE = (hz.rsE != 5'd0 && hz.rsE == hz.dstM && hz.regWriteM) ? 2'b10 :
		(hz.rsE != 5'd0 && hz.rsE == hz.dstW && hz.regWriteW) ? 2'b01 : 2'b00;
	assign hz.forwardBE = (hz.rtE != 5'd0 && hz.rtE == hz.dstM && hz.regWriteM) ? 2'b10 :
		(hz.rtE != 5'd0 && hz.rtE == hz.dstW && hz.regWriteW) ? 2'b01 : 2'b00;

	// branch compare only takes the memory stage
	assign hz.forwardAD = hz.rsD != 5'd0 && hz.rsD == hz.dstM && hz.regWriteM;
	assign hz.forwardBD = hz.rtD != 5'd0 && hz.rtD == hz.dstM && hz.regWriteM;

	//////////////////////////////
	// interlocks
	// load in execute feeding decode
	assign loadUse = hz.memToRegE && (hz.dstE == hz.rsD || hz.dstE == hz.rtD);

	// branch source still in execute, or a load in memory
	assign branchStall = hz.branchD &&
		((hz.regWriteE && hz.dstE != 5'd0 && (hz.dstE == hz.rsD || hz.dstE == hz.rtD)) ||
		(hz.memToRegM && (hz.dstM == hz.rsD || hz.dstM == hz.rtD)));

	// hold fetch and decode, bubble into execute
	assign hz.stallF = loadUse || branchStall;
	assign hz.stallD = loadUse || branchStall;
	assign hz.flushE = loadUse || branchStall;

	// a held decode leaves a bubble in execute the cycle after
	assert property (@(posedge hz.clk) hz.stallD |=> !hz.regWriteE && !hz.memToRegE)
		else $error("hazard: stallD did not leave a bubble in execute");

	// the bubble moves the load on, so load-use clears next cycle
	assert property (@(posedge hz.clk) loadUse |=> !loadUse)
		else $error("hazard: load-use stall lasted two cycles");

endmodule

// File: verilog/datapath.sv
`timescale 1ns/1ns

module datapath import mipsPkg::*; #(
	parameter int dataWidth = 32
) (
	input  logic             clk,
	input  logic             rst,
	output logic [31:0]      pcF,
	input  logic [31:0]      instrF,
	output logic             memwriteM,
	output logic [3:0]       sigWrite,
	output logic [31:0]      aluoutM,
	output logic [31:0]      writedataM,
	input  logic [31:0]      readdataM,
	output logic [31:0]      debugWbPc,
	output logic [3:0]       debugWbRfWen,
	output logic [4:0]       debugWbRfWnum,
	output logic [31:0]      debugWbRfWdata,
	output logic [31:0]      instrD,
	input  ctrlT             ctrlD,
	input  logic             isBranch,
	input  logic             branchNe,
	input  logic             isJump,
	hazardIf.datapath        hz
);

	logic [31:0]      pcPlus4F, pcNextF;
	logic [1:0][31:0] fetchF, fetchD;
	logic [31:0]      pcD, pcPlus4D, immD, branchTargetD, jumpTargetD;
	logic [4:0]       rsD, rtD, rdD;
	logic [31:0]      rd1D, rd2D, cmpAD, cmpBD;
	logic             takenD;
	idExT             idExD, idExE;
	exMemT            exMemE, exMemM;
	memWbT            memWbM, memWbW;
	logic [31:0]      srcAE, srcBE, aluBE, aluOutE;
	logic [63:0]      productE;
	logic [31:0]      hiM, loM, resultM, resultW;

	//////////////////////////////
	// fetch
	assign pcPlus4F = pcF + 32'd4;

	// decode redirects, the fetch in flight is the delay slot
	assign pcNextF = isJump ? jumpTargetD : takenD ? branchTargetD : pcPlus4F;

	always_ff @(posedge clk) begin
		if (rst) begin
			pcF <= resetPc;
		end else if (!hz.stallF) begin
			pcF <= pcNextF;
		end
	end

	// pc and instruction travel as one pair
	assign fetchF[1] = pcF;
	assign fetchF[0] = instrF;

	pipeReg #(.T(logic [1:0][31:0])) fetchDecodeReg (
		.clk(clk), .rst(rst), .stall(hz.stallD), .flush(1'b0), .d(fetchF), .q(fetchD)
	);

	//////////////////////////////
	// decode
	assign pcD      = fetchD[1];
	assign instrD   = fetchD[0];
	assign pcPlus4D = pcD + 32'd4;
	assign rsD      = instrD[25:21];
	assign rtD      = instrD[20:16];
	assign rdD      = instrD[15:11];
	assign immD     = ctrlD.zeroExt ? {16'b0, instrD[15:0]} : {{16{instrD[15]}}, instrD[15:0]};

	assign branchTargetD = pcPlus4D + {immD[29:0], 2'b00};
	assign jumpTargetD   = {pcPlus4D[31:28], instrD[25:0], 2'b00};

	regfile #(.dataWidth(dataWidth)) rf (
		.clk(clk), .ra1(rsD), .ra2(rtD), .wa(memWbW.dst), .we(memWbW.ctrl.regWrite),
		.wd(resultW), .rd1(rd1D), .rd2(rd2D)
	);

	// compare on bypassed operands
	assign cmpAD  = hz.forwardAD ? resultM : rd1D;
	assign cmpBD  = hz.forwardBD ? resultM : rd2D;
	assign takenD = isBranch && ((cmpAD == cmpBD) ^ branchNe);

	assign idExD = '{ctrl: ctrlD, pc: pcD, rs: rsD, rt: rtD, dst: ctrlD.regDst ? rdD : rtD,
		srcA: rd1D, srcB: rd2D, imm: immD};

	pipeReg #(.T(idExT)) decodeExecReg (
		.clk(clk), .rst(rst), .stall(1'b0), .flush(hz.flushE), .d(idExD), .q(idExE)
	);

	//////////////////////////////
	// execute
	always_comb begin
		case (hz.forwardAE)
			2'b10: srcAE = resultM;
			2'b01: srcAE = resultW;
			default: srcAE = idExE.srcA;
		endcase
		case (hz.forwardBE)
			2'b10: srcBE = resultM;
			2'b01: srcBE = resultW;
			default: srcBE = idExE.srcB;
		endcase
	end

	assign aluBE = idExE.ctrl.aluSrc ? idExE.imm : srcBE;

	alu #(.dataWidth(dataWidth)) aluInst (
		.a(srcAE), .b(aluBE), .op(idExE.ctrl.aluOp), .y(aluOutE)
	);

	// multiply beside the alu, hi/lo written from the memory payload
	hiloUnit #(.dataWidth(dataWidth)) hiloInst (
		.clk(clk), .rst(rst), .a(srcAE), .b(srcBE), .mulSigned(idExE.ctrl.mulSigned),
		.hiloWrite(exMemM.ctrl.hiloWrite), .productM(exMemM.product), .product(productE),
		.hi(hiM), .lo(loM)
	);

	assign exMemE = '{ctrl: idExE.ctrl, pc: idExE.pc, dst: idExE.dst, aluOut: aluOutE,
		storeData: srcBE, product: productE};

	pipeReg #(.T(exMemT)) execMemReg (
		.clk(clk), .rst(rst), .stall(1'b0), .flush(1'b0), .d(exMemE), .q(exMemM)
	);

	//////////////////////////////
	// memory
	assign memwriteM  = exMemM.ctrl.memWrite;
	// word stores only
	assign sigWrite   = {4{exMemM.ctrl.memWrite}};
	assign aluoutM    = exMemM.aluOut;
	assign writedataM = exMemM.storeData;

	// bypass value, mfhi and mflo already known here, loads stall instead
	assign resultM = (exMemM.ctrl.resultSel == resHi) ? hiM :
		(exMemM.ctrl.resultSel == resLo) ? loM : exMemM.aluOut;

	assign memWbM = '{ctrl: exMemM.ctrl, pc: exMemM.pc, dst: exMemM.dst,
		aluOut: exMemM.aluOut, readData: readdataM, hi: hiM, lo: loM};

	pipeReg #(.T(memWbT)) memWbReg (
		.clk(clk), .rst(rst), .stall(1'b0), .flush(1'b0), .d(memWbM), .q(memWbW)
	);

	//////////////////////////////
	// writeback
	always_comb begin
		case (memWbW.ctrl.resultSel)
			resMem: resultW = memWbW.readData;
			resHi: resultW = memWbW.hi;
			resLo: resultW = memWbW.lo;
			default: resultW = memWbW.aluOut;
		endcase
	end

	assign debugWbPc      = memWbW.pc;
	assign debugWbRfWen   = {4{memWbW.ctrl.regWrite}};
	assign debugWbRfWnum  = memWbW.dst;
	assign debugWbRfWdata = resultW;

	// stage numbers and flags for the hazard unit
	assign hz.rsD      = rsD;
	assign hz.rtD      = rtD;
	assign hz.branchD  = isBranch;
	assign hz.rsE      = idExE.rs;
	assign hz.rtE      = idExE.rt;
	assign hz.dstE     = idExE.dst;
	assign hz.regWriteE = idExE.ctrl.regWrite;
	assign hz.memToRegE = idExE.ctrl.resultSel == resMem;
	assign hz.dstM     = exMemM.dst;
	assign hz.regWriteM = exMemM.ctrl.regWrite;
	assign hz.memToRegM = exMemM.ctrl.resultSel == resMem;
	assign hz.dstW     = memWbW.dst;
	assign hz.regWriteW = memWbW.ctrl.regWrite;

endmodule

// File: verilog/mipsCore.sv
`timescale 1ns/1ns

module mipsCore import mipsPkg::*; #(
	parameter int dataWidth = 32
) (
	input  logic        clk,
	input  logic        rst,
	output logic [31:0] pcF,
	input  logic [31:0] instrF,
	output logic        memwriteM,
	output logic [3:0]  sigWrite,
	output logic [31:0] aluoutM,
	output logic [31:0] writedataM,
	input  logic [31:0] readdataM,
	output logic [31:0] debugWbPc,
	output logic [3:0]  debugWbRfWen,
	output logic [4:0]  debugWbRfWnum,
	output logic [31:0] debugWbRfWdata
);

	logic [31:0] instrD;
	ctrlT        ctrlD;
	logic        isBranch;
	logic        branchNe;
	logic        isJump;

	hazardIf hzIf (.clk(clk));

	// decode of the instruction held in decode
	controller ctrlInst (
		.instr(instrD), .ctrl(ctrlD), .isBranch(isBranch), .branchNe(branchNe), .isJump(isJump)
	);

	datapath #(.dataWidth(dataWidth)) dpInst (
		.clk(clk), .rst(rst), .pcF(pcF), .instrF(instrF), .memwriteM(memwriteM),
		.sigWrite(sigWrite), .aluoutM(aluoutM), .writedataM(writedataM), .readdataM(readdataM),
		.debugWbPc(debugWbPc), .debugWbRfWen(debugWbRfWen), .debugWbRfWnum(debugWbRfWnum),
		.debugWbRfWdata(debugWbRfWdata), .instrD(instrD), .ctrlD(ctrlD), .isBranch(isBranch),
		.branchNe(branchNe), .isJump(isJump), .hz(hzIf.datapath)
	);

	hazard hzInst (.hz(hzIf.hazard));

endmodule

// File: dv/coreTb.sv
`timescale 1ns/1ns

module coreTb import mipsPkg::*; ();

	logic        clk;
	logic        rst;
	logic [31:0] pcF;
	logic [31:0] instrF;
	logic        memwriteM;
	logic [3:0]  sigWrite;
	logic [31:0] aluoutM;
	logic [31:0] writedataM;
	logic [31:0] readdataM;
	logic [31:0] debugWbPc;
	logic [3:0]  debugWbRfWen;
	logic [4:0]  debugWbRfWnum;
	logic [31:0] debugWbRfWdata;

	// instruction and data memories, plus the model's copies
	logic [31:0] imem [0:255];
	logic [31:0] dmem [0:63];
	logic [31:0] mMem [0:63];
	logic [31:0] mRegs [0:31];
	logic [31:0] mHi, mLo;
	logic        mWen;
	logic [4:0]  mDst;
	logic [31:0] mVal;

	// expected writeback trace, in retire order
	logic [31:0] expPc [$];
	logic [4:0]  expNum [$];
	logic [31:0] expData [$];
	logic [31:0] ePc, eData;
	logic [4:0]  eNum;

	integer      seed;
	int          genPos;
	int          endIdx;
	logic [31:0] endPc;
	logic [4:0]  lastDst;
	int          errCount, testsRun, testsFailed, wbCount;
	logic        running;
	logic        storePend;
	logic [5:0]  storeIdx;
	logic [31:0] storeData;
	string       curName;
	int          t;

	mipsCore #(.dataWidth(32)) mipsCore_inst (
		.clk(clk), .rst(rst), .pcF(pcF), .instrF(instrF), .memwriteM(memwriteM),
		.sigWrite(sigWrite), .aluoutM(aluoutM), .writedataM(writedataM), .readdataM(readdataM),
		.debugWbPc(debugWbPc), .debugWbRfWen(debugWbRfWen), .debugWbRfWnum(debugWbRfWnum),
		.debugWbRfWdata(debugWbRfWdata)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// store lands at the edge, fetch word and load data follow 1 ns later
	always @(posedge clk) begin
		if (storePend) begin
			dmem[storeIdx] = storeData;
			storePend = 1'b0;
		end
		#1;
		instrF = imem[pcF[9:2]];
		readdataM = dmem[aluoutM[7:2]];
	end

	//////////////////////////////
	// encoding and random picks
	function automatic logic [31:0] rInstr(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
		logic [5:0] fn);
		return {opRtype, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] iInstr(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
		logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic int randBelow(int n);
		return $unsigned($random(seed)) % n;
	endfunction

	// half the sources chain on the previous result
	function automatic logic [4:0] srcReg();
		if (randBelow(2) == 0)
			return lastDst;
		return 5'(randBelow(16));
	endfunction

	function automatic logic [4:0] dstReg();
		return 5'(1 + randBelow(15));
	endfunction

	task automatic emit(input logic [31:0] w);
		imem[genPos] = w;
		genPos++;
	endtask

	//////////////////////////////
	// program generator
	task automatic genAlu();
		logic [4:0]  rs, rt, rd;
		logic [15:0] imm;
		rs = srcReg();
		rt = srcReg();
		rd = dstReg();
		imm = 16'($random(seed));
		case (randBelow(9))
			0: emit(rInstr(rs, rt, rd, fnAddu));
			1: emit(rInstr(rs, rt, rd, fnSubu));
			2: emit(rInstr(rs, rt, rd, fnAnd));
			3: emit(rInstr(rs, rt, rd, fnOr));
			4: emit(rInstr(rs, rt, rd, fnSlt));
			5: emit(iInstr(opAddiu, rs, rd, imm));
			6: emit(iInstr(opAndi, rs, rd, imm));
			7: emit(iInstr(opOri, rs, rd, imm));
			default: emit(iInstr(opLui, 5'd0, rd, imm));
		endcase
		lastDst = rd;
	endtask

	// base is always $0, word aligned inside data memory
	task automatic genMem();
		logic [15:0] off;
		logic [4:0]  rd;
		off = 16'(randBelow(64) * 4);
		rd = dstReg();
		if (randBelow(2) == 0) begin
			emit(iInstr(opSw, 5'd0, srcReg(), off));
		end else begin
			emit(iInstr(opLw, 5'd0, rd, off));
			lastDst = rd;
		end
	endtask

	// producer, then branch or jump forward, then its delay slot
	task automatic genBranch();
		logic [4:0]  rs, rt;
		logic [15:0] off;
		int          tgt;
		if (genPos > endIdx - 3) begin
			genAlu();
		end else begin
			genAlu();
			rs = lastDst;
			rt = (randBelow(2) == 0) ? lastDst : srcReg();
			tgt = genPos + 2 + randBelow(6);
			if (tgt > endIdx)
				tgt = endIdx;
			off = 16'(tgt - genPos - 1);
			case (randBelow(3))
				0: emit(iInstr(opBeq, rs, rt, off));
				1: emit(iInstr(opBne, rs, rt, off));
				default: emit({opJ, 26'(tgt)});
			endcase
			genAlu();
		end
	endtask

	// full 32-bit operands, product read back right away
	task automatic genMult();
		logic [4:0] ra, rb, rd;
		if (genPos + 7 > endIdx) begin
			genAlu();
		end else begin
			ra = dstReg();
			rb = dstReg();
			emit(iInstr(opLui, 5'd0, ra, 16'($random(seed))));
			emit(iInstr(opOri, ra, ra, 16'($random(seed))));
			emit(iInstr(opLui, 5'd0, rb, 16'($random(seed))));
			emit(iInstr(opOri, rb, rb, 16'($random(seed))));
			emit(rInstr(ra, rb, 5'd0, (randBelow(2) == 0) ? fnMult : fnMultu));
			rd = dstReg();
			emit(rInstr(5'd0, 5'd0, rd, fnMfhi));
			rd = dstReg();
			emit(rInstr(5'd0, 5'd0, rd, fnMflo));
			lastDst = rd;
		end
	endtask

	task automatic buildProgram(input int kind, input int bodyLen);
		int i;
		for (i = 0; i < 256; i++)
			imem[i] = 32'h0;
		genPos = 0;
		lastDst = 5'd1;
		// every register the body reads gets a known value
		for (i = 1; i < 16; i++)
			emit(iInstr(opAddiu, 5'd0, 5'(i), 16'($random(seed))));
		endIdx = 15 + bodyLen;
		while (genPos < endIdx) begin
			case (kind)
				0: genAlu();
				1: if (randBelow(2) == 0) genMem(); else genAlu();
				2: if (randBelow(2) == 0) genBranch(); else genAlu();
				3: if (randBelow(3) == 0) genMult(); else genAlu();
				default: begin
					case (randBelow(6))
						0, 1: genAlu();
						2, 5: genMem();
						3: genBranch();
						default: genMult();
					endcase
				end
			endcase
		end
		// self-jump with a nop in its slot
		imem[endIdx] = {opJ, 26'(endIdx)};
		imem[endIdx + 1] = 32'h0;
		endPc = endIdx * 4;
	endtask

	// pattern mixes every address bit
	task automatic fillData(input int testIdx);
		logic [31:0] addr;
		int i;
		for (i = 0; i < 64; i++) begin
			addr = i * 4;
			dmem[i] = addr * 32'h9e37_79b1 + testIdx;
			mMem[i] = dmem[i];
		end
	endtask

	//////////////////////////////
	// instruction-set model
	task automatic setWb(input logic [4:0] dst, input logic [31:0] val);
		mWen = 1'b1;
		mDst = dst;
		mVal = val;
	endtask

	task automatic runModel();
		logic [31:0] pc, npc, nnpc, ins, a, b, sImm, zImm, addr;
		logic [63:0] prod;
		int i;
		int steps;
		for (i = 0; i < 32; i++)
			mRegs[i] = '0;
		mHi = '0;
		mLo = '0;
		pc = resetPc;
		npc = resetPc + 32'd4;
		steps = 0;
		while (pc != endPc && steps < 4000) begin
			ins = imem[pc[9:2]];
			a = mRegs[ins[25:21]];
			b = mRegs[ins[20:16]];
			sImm = {{16{ins[15]}}, ins[15:0]};
			zImm = {16'd0, ins[15:0]};
			addr = a + sImm;
			nnpc = npc + 32'd4;
			mWen = 1'b0;
			case (ins[31:26])
				opRtype: begin
					case (ins[5:0])
						fnAddu: setWb(ins[15:11], a + b);
						fnSubu: setWb(ins[15:11], a - b);
						fnAnd: setWb(ins[15:11], a & b);
						fnOr: setWb(ins[15:11], a | b);
						// signs differ, the negative one is smaller
						fnSlt: setWb(ins[15:11], (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b});
						fnMult: begin
							prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
							mHi = prod[63:32];
							mLo = prod[31:0];
						end
						fnMultu: begin
							prod = {32'd0, a} * {32'd0, b};
							mHi = prod[63:32];
							mLo = prod[31:0];
						end
						fnMfhi: setWb(ins[15:11], mHi);
						fnMflo: setWb(ins[15:11], mLo);
						default: ;
					endcase
				end
				opAddiu: setWb(ins[20:16], addr);
				opAndi: setWb(ins[20:16], a & zImm);
				opOri: setWb(ins[20:16], a | zImm);
				opLui: setWb(ins[20:16], {ins[15:0], 16'd0});
				opLw: setWb(ins[20:16], mMem[addr[7:2]]);
				opSw: mMem[addr[7:2]] = b;
				// target counts from the delay slot
				opBeq: if (a == b) nnpc = npc + {sImm[29:0], 2'b00};
				opBne: if (a != b) nnpc = npc + {sImm[29:0], 2'b00};
				opJ: nnpc = {npc[31:28], ins[25:0], 2'b00};
				default: ;
			endcase
			if (mWen) begin
				mRegs[mDst] = mVal;
				expPc.push_back(pc);
				expNum.push_back(mDst);
				expData.push_back(mVal);
			end
			pc = npc;
			npc = nnpc;
			steps++;
		end
	endtask

	//////////////////////////////
	// trace and store monitor
	task automatic checkWriteback();
		wbCount++;
		if (expPc.size() == 0) begin
			$display("test %0s: writeback at pc %h when none was expected", curName, debugWbPc);
			errCount++;
		end else begin
			ePc = expPc.pop_front();
			eNum = expNum.pop_front();
			eData = expData.pop_front();
			if (debugWbRfWen !== 4'hf) begin
				$display("Fail debugWbRfWen: got %h expected %h", debugWbRfWen, 4'hf);
				errCount++;
			end
			if (debugWbPc !== ePc) begin
				$display("Fail debugWbPc: got %h expected %h", debugWbPc, ePc);
				errCount++;
			end
			if (debugWbRfWnum !== eNum) begin
				$display("Fail debugWbRfWnum: got %h expected %h", debugWbRfWnum, eNum);
				errCount++;
			end
			if (debugWbRfWdata !== eData) begin
				$display("Fail debugWbRfWdata: got %h expected %h", debugWbRfWdata, eData);
				errCount++;
			end
		end
	endtask

	// mid cycle, every output comes from a stage register
	always @(negedge clk) begin
		if (running) begin
			if (memwriteM === 1'b1) begin
				if (sigWrite !== 4'hf) begin
					$display("Fail sigWrite: got %h expected %h", sigWrite, 4'hf);
					errCount++;
				end
				storePend = 1'b1;
				storeIdx = aluoutM[7:2];
				storeData = writedataM;
			end
			if (debugWbRfWen !== 4'h0)
				checkWriteback();
		end
	end

	//////////////////////////////
	// one program per test
	task automatic runTest(input string name, input int kind, input int bodyLen);
		int   errBefore;
		int   cyc;
		int   i;
		logic seenSlot;
		logic reached;
		errBefore = errCount;
		curName = name;
		wbCount = 0;
		buildProgram(kind, bodyLen);
		fillData(testsRun);
		runModel();
		@(posedge clk);
		#1;
		rst = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		running = 1'b1;
		// out of reset, nothing retired yet
		@(negedge clk);
		if (pcF !== resetPc) begin
			$display("Fail pcF: got %h expected %h", pcF, resetPc);
			errCount++;
		end
		if (memwriteM !== 1'b0) begin
			$display("Fail memwriteM: got %h expected %h", memwriteM, 1'b0);
			errCount++;
		end
		if (debugWbRfWen !== 4'h0) begin
			$display("Fail debugWbRfWen: got %h expected %h", debugWbRfWen, 4'h0);
			errCount++;
		end
		// j in decode fetches the slot, back at endPc once it has moved on
		seenSlot = 1'b0;
		reached = 1'b0;
		for (cyc = 0; cyc < 2000 && !reached; cyc++) begin
			@(negedge clk);
			if (pcF === endPc + 32'd4)
				seenSlot = 1'b1;
			else if (seenSlot && pcF === endPc)
				reached = 1'b1;
		end
		if (!reached) begin
			$display("test %0s: timeout, self-jump not reached within 2000 cycles", name);
			errCount++;
		end else begin
			// older instructions are past decode, at most three stages left
			repeat (4) @(negedge clk);
		end
		#1;
		running = 1'b0;
		if (expPc.size() != 0) begin
			$display("test %0s: %0d expected writebacks never retired", name, expPc.size());
			errCount++;
		end
		for (i = 0; i < 64; i++) begin
			if (dmem[i] !== mMem[i]) begin
				$display("Fail dmem[%0d]: got %h expected %h", i, dmem[i], mMem[i]);
				errCount++;
			end
		end
		expPc.delete();
		expNum.delete();
		expData.delete();
		storePend = 1'b0;
		testsRun++;
		if (errCount == errBefore) begin
			$display("test %0s: ok, %0d writebacks", name, wbCount);
		end else begin
			testsFailed++;
			$display("test %0s: failed, %0d errors", name, errCount - errBefore);
		end
	endtask

	initial begin
		seed = 32'h65880c8d;
		rst = 1'b1;
		instrF = 32'h0;
		readdataM = 32'h0;
		running = 1'b0;
		storePend = 1'b0;
		storeIdx = '0;
		storeData = '0;
		errCount = 0;
		testsRun = 0;
		testsFailed = 0;
		wbCount = 0;
		runTest("alu chains", 0, 60);
		runTest("load and store", 1, 60);
		runTest("branch and jump", 2, 60);
		runTest("multiply", 3, 60);
		for (t = 0; t < 10; t++)
			runTest($sformatf("random %0d", t), 4, 120);
		$display("tests run %0d, tests failed %0d, errors %0d", testsRun, testsFailed, errCount);
		if (errCount == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// File: src.f
verilog/mipsPkg.sv
verilog/hazardIf.sv
verilog/pipeReg.sv
verilog/controller.sv
verilog/regfile.sv
verilog/alu.sv
verilog/hiloUnit.sv
verilog/hazard.sv
verilog/datapath.sv
verilog/mipsCore.sv
dv/coreTb.sv
